// ==== Bender.yml ====
package:
  name: efi_trig_unit

sources:
  - include_dirs:
      - design
    files:
      - design/efi_pkg.sv
      - design/trig_pkg.sv
      - design/trig_lut.sv
      - design/efi_trig.sv
      - design/efi_trig_unit.sv
  - target: test
    files:
      - verif/efi_trig_unit_tb.sv

// ==== design/efi_pkg.sv ====
`default_nettype none

package efi_pkg;

    // Argument and result streams carry words of the same width
    localparam int efi_data_width = 32;

    // Tag that routes a result back to its requester
    localparam int efi_dest_width = 8;

    // The first word of every request selects the function.
    // Any other value is answered with a single zero word.
    typedef enum logic [efi_data_width-1:0] {
        op_sin    = 32'd0,
        op_cos    = 32'd1,
        op_sincos = 32'd2
    } efi_opcode_e;

endpackage

`default_nettype wire

// ==== design/efi_trig.sv ====
`default_nettype none

module efi_trig import efi_pkg::*, trig_pkg::*; (
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire                       arguments_valid,
    output logic                      arguments_ready,
    input  wire  [efi_data_width-1:0] arguments_data,
    input  wire  [efi_dest_width-1:0] arguments_dest,
    input  wire                       arguments_last,
    output logic                      results_valid,
    input  wire                       results_ready,
    output logic [efi_data_width-1:0] results_data,
    output logic [efi_dest_width-1:0] results_dest,
    output logic                      results_last,
    output logic                      phase_valid,
    output trig_phase_t               phase,
    input  wire                       sample_valid,
    input  wire trig_sample_t         sin_sample,
    input  wire trig_sample_t         cos_sample
);

    typedef enum logic [2:0] {
        idle,
        collect,
        wait_sample,
        send_first,
        send_second
    } state_e;

    state_e       state;
    efi_opcode_e  opcode_q;
    logic         phase_seen;
    logic         have_samples;
    trig_sample_t sin_q;
    trig_sample_t cos_q;

    logic         arguments_xfer;
    logic         results_xfer;
    logic         known_op;
    logic         table_op;
    logic         first_ready;
    trig_sample_t sin_now;
    trig_sample_t cos_now;

    function automatic logic [efi_data_width-1:0] widen(input trig_sample_t s);
        widen = {{(efi_data_width - trig_sample_width){s[trig_sample_width-1]}}, s};
    endfunction

    assign arguments_ready = (state == idle) || (state == collect);
    assign arguments_xfer  = arguments_valid && arguments_ready;
    assign results_xfer    = results_valid && results_ready;

    assign known_op = opcode_q inside {op_sin, op_cos, op_sincos};

    // Only a known opcode that came with a phase word uses the table
    assign table_op = phase_seen && known_op;

    // Samples may arrive while surplus words are still being drained,
    // so the first word comes from the live samples or from the copy
    assign sin_now     = sample_valid ? sin_sample : sin_q;
    assign cos_now     = sample_valid ? cos_sample : cos_q;
    assign first_ready = !table_op || sample_valid || have_samples;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state         <= idle;
            phase_seen    <= 1'b0;
            have_samples  <= 1'b0;
            phase_valid   <= 1'b0;
            results_valid <= 1'b0;
            results_last  <= 1'b0;
        end else begin
            phase_valid <= 1'b0;
            if (sample_valid) begin
                have_samples <= 1'b1;
            end
            case (state)
                idle: begin
                    phase_seen <= 1'b0;
                    if (arguments_xfer) begin
                        state <= arguments_last ? wait_sample : collect;
                    end
                end
                collect: begin
                    if (arguments_xfer) begin
                        // The first word after the opcode is the phase, later ones are dropped
                        if (!phase_seen) begin
                            phase_seen  <= 1'b1;
                            phase_valid <= known_op;
                        end
                        if (arguments_last) begin
                            state <= wait_sample;
                        end
                    end
                end
                wait_sample: begin
                    if (first_ready) begin
                        state         <= send_first;
                        have_samples  <= 1'b0;
                        results_valid <= 1'b1;
                        results_last  <= !(table_op && (opcode_q == op_sincos));
                    end
                end
                send_first: begin
                    if (results_xfer) begin
                        if (results_last) begin
                            state         <= idle;
                            results_valid <= 1'b0;
                            results_last  <= 1'b0;
                        end else begin
                            state        <= send_second;
                            results_last <= 1'b1;
                        end
                    end
                end
                send_second: begin
                    if (results_xfer) begin
                        state         <= idle;
                        results_valid <= 1'b0;
                        results_last  <= 1'b0;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (sample_valid) begin
            sin_q <= sin_sample;
            cos_q <= cos_sample;
        end
        if (arguments_xfer) begin
            if (state == idle) begin
                opcode_q     <= efi_opcode_e'(arguments_data);
                // Stands in as the tag when no phase word follows
                results_dest <= arguments_dest;
            end else if (!phase_seen) begin
                phase        <= arguments_data[trig_phase_width-1:0];
                results_dest <= arguments_dest;
            end
        end
        if (state == wait_sample && first_ready) begin
            if (!table_op) begin
                results_data <= '0;
            end else if (opcode_q == op_cos) begin
                results_data <= widen(cos_now);
            end else begin
                results_data <= widen(sin_now);
            end
        end else if (state == send_first && results_xfer && !results_last) begin
            results_data <= widen(cos_q);
        end
    end

    // A stalled result word stays put until the consumer takes it
    assert property (@(posedge clock) disable iff (!rst_n)
        results_valid && !results_ready |=> results_valid && $stable(results_data) &&
            $stable(results_dest) && $stable(results_last))
        else $error("efi_trig: result word changed while stalled");

endmodule

`default_nettype wire

// ==== design/efi_trig_unit.sv ====
`default_nettype none

module efi_trig_unit import efi_pkg::*, trig_pkg::*; (
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire                       arguments_valid,
    output wire                       arguments_ready,
    input  wire  [efi_data_width-1:0] arguments_data,
    input  wire  [efi_dest_width-1:0] arguments_dest,
    input  wire                       arguments_last,
    output wire                       results_valid,
    input  wire                       results_ready,
    output wire  [efi_data_width-1:0] results_data,
    output wire  [efi_dest_width-1:0] results_dest,
    output wire                       results_last
);

    // Link between the sequencer and the lookup, which has no back-pressure
    wire               phase_valid;
    wire trig_phase_t  phase;
    wire               sample_valid;
    wire trig_sample_t sin_sample;
    wire trig_sample_t cos_sample;

    efi_trig u_sequencer (
        .clock           (clock),
        .rst_n           (rst_n),
        .arguments_valid (arguments_valid),
        .arguments_ready (arguments_ready),
        .arguments_data  (arguments_data),
        .arguments_dest  (arguments_dest),
        .arguments_last  (arguments_last),
        .results_valid   (results_valid),
        .results_ready   (results_ready),
        .results_data    (results_data),
        .results_dest    (results_dest),
        .results_last    (results_last),
        .phase_valid     (phase_valid),
        .phase           (phase),
        .sample_valid    (sample_valid),
        .sin_sample      (sin_sample),
        .cos_sample      (cos_sample)
    );

    trig_lut u_lut (
        .clock        (clock),
        .rst_n        (rst_n),
        .phase_valid  (phase_valid),
        .phase        (phase),
        .sample_valid (sample_valid),
        .sin_sample   (sin_sample),
        .cos_sample   (cos_sample)
    );

endmodule

`default_nettype wire

// ==== design/trig_lut.sv ====
`default_nettype none

module trig_lut import trig_pkg::*; (
    input  wire               clock,
    input  wire               rst_n,
    input  wire               phase_valid,
    input  wire trig_phase_t  phase,
    output logic              sample_valid,
    output trig_sample_t      sin_sample,
    output trig_sample_t      cos_sample
);

    `include "trig_sine_table.svh"

    localparam trig_phase_t half_turn = trig_phase_t'(2 * trig_quarter_turn);

    trig_phase_t cos_phase;
    logic [1:0]  sin_quadrant;
    logic [1:0]  cos_quadrant;

    logic        s1_valid;
    trig_addr_t  s1_sin_addr;
    trig_addr_t  s1_cos_addr;
    logic        s1_sin_neg;
    logic        s1_cos_neg;

    // Odd quadrants walk the table backwards from the peak
    function automatic trig_addr_t fold_addr(input logic [1:0] quadrant,
                                             input logic [trig_index_width-1:0] index);
        trig_addr_t addr;
        addr = trig_addr_t'(index);
        if (quadrant[0]) begin
            addr = trig_addr_t'(trig_quarter_turn) - addr;
        end
        return addr;
    endfunction

    // Cosine is the sine a quarter turn ahead, the add wraps at a full turn
    assign cos_phase    = phase + trig_phase_t'(trig_quarter_turn);
    assign sin_quadrant = phase[trig_phase_width-1 -: 2];
    assign cos_quadrant = cos_phase[trig_phase_width-1 -: 2];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            s1_valid     <= phase_valid;
            sample_valid <= s1_valid;
        end
    end

    // Stage 1 folds both phases into a table address and a sign
    always_ff @(posedge clock) begin
        if (phase_valid) begin
            s1_sin_addr <= fold_addr(sin_quadrant, phase[trig_index_width-1:0]);
            s1_cos_addr <= fold_addr(cos_quadrant, cos_phase[trig_index_width-1:0]);
            // The lower half of the turn is negative
            s1_sin_neg  <= sin_quadrant[1];
            s1_cos_neg  <= cos_quadrant[1];
        end
    end

    // Stage 2 reads the table and applies the sign
    always_ff @(posedge clock) begin
        if (s1_valid) begin
            if (s1_sin_neg) begin
                sin_sample <= -trig_sine_table[s1_sin_addr];
            end else begin
                sin_sample <= trig_sine_table[s1_sin_addr];
            end
            if (s1_cos_neg) begin
                cos_sample <= -trig_sine_table[s1_cos_addr];
            end else begin
                cos_sample <= trig_sine_table[s1_cos_addr];
            end
        end
    end

    // Both samples take their sign from the phase issued two cycles earlier
    assert property (@(posedge clock) disable iff (!rst_n)
        sample_valid |->
            (sin_sample[trig_sample_width-1] == ($past(phase, 2) > half_turn)) &&
            (cos_sample[trig_sample_width-1] ==
                (trig_phase_t'($past(phase, 2) + trig_quarter_turn) > half_turn)))
        else $error("trig_lut: sample sign does not match the phase two cycles earlier");

endmodule

`default_nettype wire

// ==== design/trig_pkg.sv ====
`default_nettype none

package trig_pkg;

    // One full turn is 256 phase steps
    localparam int trig_phase_width = 8;

    // Offset inside one quadrant, the two bits above it select the quadrant
    localparam int trig_index_width = 6;

    // Quarter wave with both end points, so 0 and 90 degrees are exact
    localparam int trig_table_depth = 65;

    localparam int trig_sample_width = 16;

    // Sample value that stands for 1.0
    localparam int trig_full_scale = 16383;

    // Phase offset that turns a sine lookup into a cosine lookup
    localparam int trig_quarter_turn = 64;

    typedef logic [trig_phase_width-1:0] trig_phase_t;

    // Table address, one bit wider than the index to reach entry 64
    typedef logic [trig_index_width:0] trig_addr_t;

    typedef logic signed [trig_sample_width-1:0] trig_sample_t;

endpackage

`default_nettype wire

// ==== design/trig_sine_table.svh ====
`ifndef TRIG_SINE_TABLE_SVH
`define TRIG_SINE_TABLE_SVH

// Entry i holds round(16383 * sin(i * pi / 128)) for i from 0 to 64
localparam trig_sample_t trig_sine_table [trig_table_depth] = '{
    16'sd0,
    16'sd402,
    16'sd804,
    16'sd1205,
    16'sd1606,
    16'sd2005,
    16'sd2404,
    16'sd2801,
    // 11.25 degrees
    16'sd3196,
    16'sd3590,
    16'sd3981,
    16'sd4370,
    16'sd4756,
    16'sd5139,
    16'sd5519,
    16'sd5896,
    // 22.5 degrees
    16'sd6270,
    16'sd6639,
    16'sd7005,
    16'sd7366,
    16'sd7723,
    16'sd8075,
    16'sd8423,
    16'sd8765,
    16'sd9102,
    16'sd9433,
    16'sd9759,
    16'sd10079,
    16'sd10393,
    16'sd10701,
    16'sd11002,
    16'sd11297,
    // 45 degrees
    16'sd11585,
    16'sd11865,
    16'sd12139,
    16'sd12405,
    16'sd12664,
    16'sd12915,
    16'sd13159,
    16'sd13394,
    16'sd13622,
    16'sd13841,
    16'sd14052,
    16'sd14255,
    16'sd14449,
    16'sd14634,
    16'sd14810,
    16'sd14977,
    // 67.5 degrees
    16'sd15136,
    16'sd15285,
    16'sd15425,
    16'sd15556,
    16'sd15678,
    16'sd15790,
    16'sd15892,
    16'sd15985,
    16'sd16068,
    16'sd16142,
    16'sd16206,
    16'sd16260,
    16'sd16304,
    16'sd16339,
    16'sd16363,
    16'sd16378,
    // Peak at a quarter turn
    trig_sample_t'(trig_full_scale)
};

`endif

// ==== efi_trig_unit.f ====
+incdir+design
design/efi_pkg.sv
design/trig_pkg.sv
design/trig_lut.sv
design/efi_trig.sv
design/efi_trig_unit.sv
verif/efi_trig_unit_tb.sv

// ==== verif/efi_trig_trace.txt ====
// Request trace for efi_trig_unit, all values in hex.
// First word is the record count. Each record then holds:
// opcode phase n_surplus surplus... dest stalls n_results (data last)...
11
// Sine in all four quadrants, including the quadrant boundaries
0 00 0 11 0 1 00000000 1
0 40 0 12 0 1 00003fff 1
0 80 0 13 0 1 00000000 1
0 c0 0 14 0 1 ffffc001 1
0 25 0 15 0 1 00003273 1
0 64 0 16 0 1 00002899 1
0 96 0 17 0 1 ffffdf19 1
0 e6 0 18 0 1 ffffd9e1 1
// Cosine, one word each
1 00 0 21 0 1 00003fff 1
1 20 0 22 0 1 00002d41 1
1 a0 0 23 0 1 ffffd2bf 1
// Sine and cosine, the second one under back-pressure
2 10 0 31 0 2 0000187e 0 00003b20 1
2 b5 0 32 6 2 ffffc252 0 ffffeeee 1
// Single sine word under back-pressure
0 70 0 41 4 1 0000187e 1
// Two surplus words before last
0 30 2 abcd0001 abcd0002 51 0 1 00003b20 1
// Unknown opcode, then a normal request
7 40 0 52 0 1 00000000 1
1 55 0 53 0 1 ffffe075 1

// ==== verif/efi_trig_unit_tb.sv ====
`default_nettype none

module efi_trig_unit_tb import efi_pkg::*, trig_pkg::*; ();

    localparam int clock_period = 20;
    localparam int drive_delay  = 1;
    localparam int wait_limit   = 100;
    localparam int trace_words  = 256;

    logic                      clock;
    logic                      rst_n;
    logic                      arguments_valid;
    wire                       arguments_ready;
    logic [efi_data_width-1:0] arguments_data;
    logic [efi_dest_width-1:0] arguments_dest;
    logic                      arguments_last;
    wire                       results_valid;
    logic                      results_ready;
    wire  [efi_data_width-1:0] results_data;
    wire  [efi_dest_width-1:0] results_dest;
    wire                       results_last;

    logic [31:0] trace_mem [trace_words];
    int          trace_pos;
    int          cycle = 0;
    int          phase_cycle;

    // Expected words of the request in progress, at most sine then cosine
    logic [31:0] exp_data [2];
    logic        exp_last [2];
    int          exp_count;

    efi_trig_unit u_dut (
        .clock           (clock),
        .rst_n           (rst_n),
        .arguments_valid (arguments_valid),
        .arguments_ready (arguments_ready),
        .arguments_data  (arguments_data),
        .arguments_dest  (arguments_dest),
        .arguments_last  (arguments_last),
        .results_valid   (results_valid),
        .results_ready   (results_ready),
        .results_data    (results_data),
        .results_dest    (results_dest),
        .results_last    (results_last)
    );

    always #(clock_period / 2) clock = ~clock;

    // Edge counter used to measure the result latency
    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic require(input logic condition, input string reason);
        assert (condition) else stop_run(reason);
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            stop_run($sformatf("ERR time %0t %s expected %0h actual %0h",
                               $time, name, expected, actual));
        end
    endtask

    function automatic logic [31:0] next_word();
        next_word = trace_mem[trace_pos];
        trace_pos++;
    endfunction

    // Holds one argument word on the bus until the DUT accepts it
    task automatic send_word(input logic [31:0] data, input logic last);
        int waited;
        waited          = 0;
        arguments_valid = 1'b1;
        arguments_data  = data;
        arguments_last  = last;
        @(negedge clock);
        while (!arguments_ready) begin
            waited++;
            require(waited < wait_limit, "timeout while waiting for arguments_ready");
            @(negedge clock);
        end
        @(posedge clock);
        #drive_delay;
    endtask

    task automatic collect_results(input logic [efi_dest_width-1:0] dest, input int stalls,
                                   input logic check_latency);
        int   taken;
        int   waited;
        int   stalls_left;
        logic seen_valid;
        taken       = 0;
        waited      = 0;
        stalls_left = stalls;
        seen_valid  = 1'b0;
        while (taken < exp_count) begin
            // Back-pressure only lands on cycles that present a word
            if (results_valid && stalls_left > 0 && ($urandom % 2) == 0) begin
                results_ready = 1'b0;
                stalls_left--;
            end else begin
                results_ready = 1'b1;
            end
            @(negedge clock);
            waited++;
            require(waited < wait_limit, "timeout while waiting for a result word");
            require(!arguments_ready, "arguments_ready rose before the final result word");
            if (results_valid) begin
                if (!seen_valid && check_latency) begin
                    compare_value("result latency", 32'd3, cycle - phase_cycle);
                end
                seen_valid = 1'b1;
                // A stalled word is compared again on every cycle it is held
                compare_value("results_data", exp_data[taken], results_data);
                compare_value("results_dest", 32'(dest), 32'(results_dest));
                compare_value("results_last", 32'(exp_last[taken]), 32'(results_last));
                if (results_ready) begin
                    taken++;
                end
            end
            @(posedge clock);
            #drive_delay;
        end
        results_ready = 1'b1;
        @(negedge clock);
        require(!results_valid, "an extra result word followed the final one");
        require(arguments_ready, "arguments_ready stayed low after the final result word");
        @(posedge clock);
        #drive_delay;
    endtask

    task automatic run_request();
        logic [31:0] opcode;
        logic [31:0] phase_word;
        logic [31:0] n_surplus;
        logic [31:0] dest;
        logic [31:0] stalls;
        logic [31:0] last_word;
        logic        check_latency;
        opcode     = next_word();
        phase_word = next_word();
        n_surplus  = next_word();
        check_latency = (n_surplus == 0) &&
                        (efi_opcode_e'(opcode) inside {op_sin, op_cos, op_sincos});
        send_word(opcode, 1'b0);
        send_word({24'd0, phase_word[trig_phase_width-1:0]}, n_surplus == 0);
        phase_cycle = cycle;
        for (int i = 0; i < n_surplus; i++) begin
            send_word(next_word(), i == n_surplus - 1);
        end
        arguments_valid = 1'b0;
        arguments_last  = 1'b0;
        dest      = next_word();
        stalls    = next_word();
        exp_count = next_word();
        require(exp_count == 1 || exp_count == 2, "trace record has a bad result count");
        for (int k = 0; k < exp_count; k++) begin
            exp_data[k] = next_word();
            last_word   = next_word();
            exp_last[k] = last_word[0];
        end
        collect_results(dest[efi_dest_width-1:0], stalls, check_latency);
    endtask

    initial begin
        int n_records;
        void'($urandom(35804));
        clock           = 1'b0;
        rst_n           = 1'b0;
        arguments_valid = 1'b0;
        arguments_data  = '0;
        arguments_dest  = '0;
        arguments_last  = 1'b0;
        results_ready   = 1'b1;
        $readmemh("verif/efi_trig_trace.txt", trace_mem);
        trace_pos = 0;
        n_records = next_word();
        require(!$isunknown(trace_mem[0]), "trace file could not be read");
        repeat (5) @(posedge clock);
        #drive_delay;
        rst_n = 1'b1;
        @(negedge clock);
        require(arguments_ready, "arguments_ready is low after reset");
        require(!results_valid, "results_valid is high after reset");
        @(posedge clock);
        #drive_delay;
        for (int r = 0; r < n_records; r++) begin
            // All words of one request share the tag
            arguments_dest = trace_mem[trace_pos + 3 + trace_mem[trace_pos + 2]][efi_dest_width-1:0];
            run_request();
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
